// File: hdl/im2col_addr_pipe.sv
/*
 * im2col address pipeline.
 * Source index in four stages, input and output pointers, row increment.
 */

`timescale 1ns/1ps

`include "im2col_settings.svh"

module im2col_addr_pipe (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     pipe_en_i,
  input  logic                     out_adv_i,
  input  logic                     out_clr_i,
  input  im2col_pkg::ptr_t         src_ptr_i,
  input  im2col_pkg::ptr_t         dst_ptr_i,
  input  im2col_pkg::dim_t         ih_i,
  input  im2col_pkg::dim_t         iw_i,
  input  im2col_pkg::dim_t         num_ch_i,
  input  im2col_pkg::size_t        n_patches_h_i,
  input  im2col_pkg::size_t        n_patches_w_i,
  input  im2col_pkg::dim_t         pad_top_i,
  input  im2col_pkg::dim_t         pad_left_i,
  input  im2col_pkg::dim_t         batch_cnt_i,
  input  im2col_pkg::dim_t         im_c_i,
  input  im2col_pkg::dim_t         h_off_i,
  input  im2col_pkg::dim_t         w_off_i,
  input  im2col_pkg::dim_t         n_zeros_top_i,
  input  im2col_pkg::dim_t         n_zeros_left_i,
  input  im2col_pkg::size_t        size_d1_i,
  output im2col_pkg::ptr_t         input_ptr_o,
  output im2col_pkg::ptr_t         output_ptr_o,
  output logic [`IM2COL_INC_W-1:0] in_inc_d2_o
);
  import im2col_pkg::*;

  ptr_t plane_q;  // Channel plane number.
  ptr_t row_base_q;
  ptr_t row_q;  // Image row of the first valid element.
  ptr_t index;
  ptr_t in_ptr_q;
  ptr_t out_ptr_q;
  ptr_t out_step;

  // Rows and columns may start negative; padding brings them back in range.
  always_ff @(posedge clk_i) begin
    if (pipe_en_i) begin
      plane_q    <= ptr_t'(batch_cnt_i) * ptr_t'(num_ch_i) + ptr_t'(im_c_i);
      row_base_q <= plane_q * ptr_t'(ih_i);
      row_q      <= row_base_q + ptr_t'(h_off_i) + ptr_t'(n_zeros_top_i)
                    - ptr_t'(pad_top_i);
      in_ptr_q   <= src_ptr_i + (index << `IM2COL_ELEM_BYTES_LOG2);
    end
  end

  assign index = row_q * ptr_t'(iw_i) + ptr_t'(w_off_i) + ptr_t'(n_zeros_left_i)
                 - ptr_t'(pad_left_i);

  // One full output column per descriptor.
  assign out_step = (ptr_t'(n_patches_h_i) * ptr_t'(n_patches_w_i))
                    << `IM2COL_ELEM_BYTES_LOG2;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ptr_q <= '0;
    end else if (out_clr_i) begin
      out_ptr_q <= dst_ptr_i;
    end else if (out_adv_i) begin
      out_ptr_q <= out_ptr_q + out_step;
    end
  end

  assign input_ptr_o  = in_ptr_q;
  assign output_ptr_o = out_ptr_q;
  assign in_inc_d2_o  = `IM2COL_INC_W'(iw_i) - `IM2COL_INC_W'(size_d1_i) + 1'b1;

endmodule

// File: hdl/im2col_ctrl.sv
/*
 * im2col parameter engine control.
 * Sequences the descriptor computation, pushes to the FIFO, keeps done.
 */

`timescale 1ns/1ps

module im2col_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic fifo_full_i,
  input  logic done_ack_i,
  input  logic last_batch_i,
  input  logic last_col_i,
  output logic fifo_push_o,
  output logic param_done_o,
  output logic phase1_en_o,
  output logic phase2_en_o,
  output logic zeros_clr_o,
  output logic batch_inc_o,
  output logic batch_clr_o,
  output logic offset_adv_o,
  output logic out_adv_o,
  output logic out_clr_o,
  output logic pipe_en_o
);
  import im2col_pkg::*;

  param_state_e state_q, state_d;
  logic done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Set after the last column, held until acknowledged.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (done_ack_i) begin
      done_q <= 1'b0;
    end else if (state_q == OFFSET_UPDATE && last_col_i) begin
      done_q <= 1'b1;
    end
  end

  always_comb begin
    state_d      = state_q;
    fifo_push_o  = 1'b0;
    phase1_en_o  = 1'b0;
    phase2_en_o  = 1'b0;
    zeros_clr_o  = 1'b0;
    batch_inc_o  = 1'b0;
    batch_clr_o  = 1'b0;
    offset_adv_o = 1'b0;
    out_adv_o    = 1'b0;
    out_clr_o    = 1'b0;
    pipe_en_o    = 1'b0;
    unique case (state_q)
      IDLE, PRECOMP: begin
        zeros_clr_o = 1'b1;
        batch_clr_o = 1'b1;
        out_clr_o   = 1'b1;  // Reload destination pointer.
        if (state_q == PRECOMP) begin
          state_d = COND_EVAL;
        end else if (start_i) begin
          state_d = PRECOMP;
        end
      end
      COND_EVAL: state_d = done_q ? IDLE : ZEROS_1;
      ZEROS_1: begin
        phase1_en_o = 1'b1;
        state_d     = ZEROS_2;
      end
      ZEROS_2: begin
        phase2_en_o = 1'b1;
        pipe_en_o   = 1'b1;
        state_d     = INDEX_1;
      end
      INDEX_1, INDEX_2: begin
        pipe_en_o = 1'b1;
        state_d   = (state_q == INDEX_1) ? INDEX_2 : INDEX_3;
      end
      INDEX_3: begin
        pipe_en_o = 1'b1;
        if (!fifo_full_i) begin
          state_d = PUSH;
        end
      end
      PUSH: begin
        fifo_push_o = 1'b1;
        state_d     = OUT_UPDATE;
      end
      OUT_UPDATE: begin
        batch_inc_o = 1'b1;
        out_adv_o   = 1'b1;
        state_d     = last_batch_i ? OFFSET_UPDATE : COND_EVAL;
      end
      OFFSET_UPDATE: begin
        batch_clr_o  = 1'b1;
        offset_adv_o = 1'b1;  // Next filter tap or channel.
        state_d      = COND_EVAL;
      end
      default: state_d = IDLE;
    endcase
  end

  assign param_done_o = done_q;

  // A push only follows an INDEX_3 cycle that saw room in the FIFO.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_push_o |-> $past(state_q == INDEX_3 && !fifo_full_i));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    param_done_o |-> !fifo_push_o);

endmodule

// File: hdl/im2col_pad_calc.sv
/*
 * im2col padding calculation.
 * Zero counts on the four sides in two phases, and the transfer sizes.
 */

`timescale 1ns/1ps

module im2col_pad_calc (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  im2col_pkg::dim_t  w_off_i,
  input  im2col_pkg::dim_t  h_off_i,
  input  im2col_pkg::dim_t  fw_i,
  input  im2col_pkg::dim_t  fh_i,
  input  im2col_pkg::dim_t  pad_top_i,
  input  im2col_pkg::dim_t  pad_bottom_i,
  input  im2col_pkg::dim_t  pad_left_i,
  input  im2col_pkg::dim_t  pad_right_i,
  input  im2col_pkg::size_t n_patches_h_i,
  input  im2col_pkg::size_t n_patches_w_i,
  input  logic              phase1_en_i,
  input  logic              phase2_en_i,
  input  logic              zeros_clr_i,
  output im2col_pkg::dim_t  n_zeros_top_o,
  output im2col_pkg::dim_t  n_zeros_bottom_o,
  output im2col_pkg::dim_t  n_zeros_left_o,
  output im2col_pkg::dim_t  n_zeros_right_o,
  output im2col_pkg::size_t size_d1_o,
  output im2col_pkg::size_t size_d2_o
);
  import im2col_pkg::*;

  dim_t dist_w_q, dist_h_q;  // Distance of the tap to the far filter edge.
  dim_t top_q, bottom_q, left_q, right_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dist_w_q <= '0;
      dist_h_q <= '0;
    end else if (phase1_en_i) begin
      dist_w_q <= fw_i - 1'b1 - w_off_i;
      dist_h_q <= fh_i - 1'b1 - h_off_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {top_q, bottom_q, left_q, right_q} <= '0;
    end else if (phase2_en_i) begin
      top_q    <= (pad_top_i > h_off_i) ? pad_top_i - h_off_i : '0;
      left_q   <= (pad_left_i > w_off_i) ? pad_left_i - w_off_i : '0;
      bottom_q <= (pad_bottom_i > dist_h_q) ? pad_bottom_i - dist_h_q : '0;
      right_q  <= (pad_right_i > dist_w_q) ? pad_right_i - dist_w_q : '0;
    end else if (zeros_clr_i) begin
      {top_q, bottom_q, left_q, right_q} <= '0;
    end
  end

  assign n_zeros_top_o    = top_q;
  assign n_zeros_bottom_o = bottom_q;
  assign n_zeros_left_o   = left_q;
  assign n_zeros_right_o  = right_q;

  // Valid elements per row and per column of the patch.
  assign size_d1_o = n_patches_w_i - size_t'(left_q) - size_t'(right_q);
  assign size_d2_o = n_patches_h_i - size_t'(top_q) - size_t'(bottom_q);

endmodule

// File: hdl/im2col_param_top.sv
/*
 * im2col parameter engine top level.
 * Control FSM with counters, padding and address datapath.
 */

`timescale 1ns/1ps

`include "im2col_settings.svh"

module im2col_param_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  im2col_pkg::ptr_t      src_ptr_i,
  input  im2col_pkg::ptr_t      dst_ptr_i,
  input  im2col_pkg::dim_t      ih_i,
  input  im2col_pkg::dim_t      iw_i,
  input  im2col_pkg::dim_t      fh_i,
  input  im2col_pkg::dim_t      fw_i,
  input  im2col_pkg::dim_t      num_ch_i,
  input  im2col_pkg::size_t     ch_col_i,
  input  im2col_pkg::dim_t      batch_i,
  input  im2col_pkg::size_t     n_patches_h_i,
  input  im2col_pkg::size_t     n_patches_w_i,
  input  im2col_pkg::dim_t      pad_top_i,
  input  im2col_pkg::dim_t      pad_bottom_i,
  input  im2col_pkg::dim_t      pad_left_i,
  input  im2col_pkg::dim_t      pad_right_i,
  input  logic                  start_i,
  input  logic                  fifo_full_i,
  input  logic                  done_ack_i,
  output logic                  fifo_push_o,
  output logic                  param_done_o,
  output im2col_pkg::dma_desc_t desc_o
);
  import im2col_pkg::*;

  logic phase1_en, phase2_en, zeros_clr, batch_inc, batch_clr;
  logic offset_adv, out_adv, out_clr, pipe_en;
  logic last_batch, last_col;
  dim_t w_off, h_off, im_c, batch_cnt;
  dim_t n_zeros_top, n_zeros_bottom, n_zeros_left, n_zeros_right;
  size_t size_d1, size_d2;
  ptr_t input_ptr, output_ptr;
  logic [`IM2COL_INC_W-1:0] in_inc_d2;

  im2col_ctrl ctrl_i (
    .clk_i, .rst_ni, .start_i, .fifo_full_i, .done_ack_i,
    .last_batch_i (last_batch),
    .last_col_i   (last_col),
    .fifo_push_o, .param_done_o,
    .phase1_en_o  (phase1_en),
    .phase2_en_o  (phase2_en),
    .zeros_clr_o  (zeros_clr),
    .batch_inc_o  (batch_inc),
    .batch_clr_o  (batch_clr),
    .offset_adv_o (offset_adv),
    .out_adv_o    (out_adv),
    .out_clr_o    (out_clr),
    .pipe_en_o    (pipe_en)
  );

  im2col_window_cnt window_cnt_i (
    .clk_i, .rst_ni, .fh_i, .fw_i, .ch_col_i, .batch_i,
    .offset_adv_i (offset_adv),
    .batch_inc_i  (batch_inc),
    .batch_clr_i  (batch_clr),
    .done_i       (param_done_o),
    .w_off_o      (w_off),
    .h_off_o      (h_off),
    .im_c_o       (im_c),
    .batch_cnt_o  (batch_cnt),
    .last_batch_o (last_batch),
    .last_col_o   (last_col)
  );

  im2col_pad_calc pad_calc_i (
    .clk_i, .rst_ni, .fw_i, .fh_i,
    .w_off_i (w_off),
    .h_off_i (h_off),
    .pad_top_i, .pad_bottom_i, .pad_left_i, .pad_right_i,
    .n_patches_h_i, .n_patches_w_i,
    .phase1_en_i      (phase1_en),
    .phase2_en_i      (phase2_en),
    .zeros_clr_i      (zeros_clr),
    .n_zeros_top_o    (n_zeros_top),
    .n_zeros_bottom_o (n_zeros_bottom),
    .n_zeros_left_o   (n_zeros_left),
    .n_zeros_right_o  (n_zeros_right),
    .size_d1_o        (size_d1),
    .size_d2_o        (size_d2)
  );

  im2col_addr_pipe addr_pipe_i (
    .clk_i, .rst_ni,
    .pipe_en_i (pipe_en),
    .out_adv_i (out_adv),
    .out_clr_i (out_clr),
    .src_ptr_i, .dst_ptr_i, .ih_i, .iw_i, .num_ch_i,
    .n_patches_h_i, .n_patches_w_i, .pad_top_i, .pad_left_i,
    .batch_cnt_i    (batch_cnt),
    .im_c_i         (im_c),
    .h_off_i        (h_off),
    .w_off_i        (w_off),
    .n_zeros_top_i  (n_zeros_top),
    .n_zeros_left_i (n_zeros_left),
    .size_d1_i      (size_d1),
    .input_ptr_o    (input_ptr),
    .output_ptr_o   (output_ptr),
    .in_inc_d2_o    (in_inc_d2)
  );

  assign desc_o = '{
    input_ptr:      input_ptr,
    output_ptr:     output_ptr,
    in_inc_d2:      in_inc_d2,
    n_zeros_top:    n_zeros_top,
    n_zeros_bottom: n_zeros_bottom,
    n_zeros_left:   n_zeros_left,
    n_zeros_right:  n_zeros_right,
    size_d1:        size_d1,
    size_d2:        size_d2
  };

endmodule

// File: hdl/im2col_pkg.sv
/*
 * im2col parameter engine package.
 * Dimension, pointer and size types, FSM states and the DMA descriptor.
 */

`include "im2col_settings.svh"

package im2col_pkg;

  typedef logic [`IM2COL_DIM_W-1:0] dim_t;
  typedef logic [`IM2COL_SIZE_W-1:0] size_t;
  typedef logic [`IM2COL_PTR_W-1:0] ptr_t;

  typedef enum logic [3:0] {
    IDLE,
    PRECOMP,
    COND_EVAL,
    ZEROS_1,
    ZEROS_2,
    INDEX_1,
    INDEX_2,
    INDEX_3,
    PUSH,
    OUT_UPDATE,
    OFFSET_UPDATE
  } param_state_e;

  // One DMA transfer of the im2col matrix.
  typedef struct packed {
    ptr_t input_ptr;
    ptr_t output_ptr;
    logic [`IM2COL_INC_W-1:0] in_inc_d2;  // Source step between rows.
    dim_t n_zeros_top;
    dim_t n_zeros_bottom;
    dim_t n_zeros_left;
    dim_t n_zeros_right;
    size_t size_d1;
    size_t size_d2;
  } dma_desc_t;

endpackage

// File: hdl/im2col_settings.svh
/*
 * im2col parameter engine settings.
 * Datapath widths and descriptor field widths.
 */

`ifndef IM2COL_SETTINGS_SVH
`define IM2COL_SETTINGS_SVH

// Image, filter, padding and counter dimensions.
`define IM2COL_DIM_W 8

// Transfer sizes and patch counts.
`define IM2COL_SIZE_W 16

`define IM2COL_PTR_W 32  // Addresses and element index.

`define IM2COL_INC_W 23  // Row increment field of the descriptor.

`define IM2COL_ELEM_BYTES_LOG2 2  // 32-bit elements.

`endif

// File: hdl/im2col_window_cnt.sv
/*
 * im2col window counters.
 * Filter offsets, channel, column and batch position of the walk.
 */

`timescale 1ns/1ps

module im2col_window_cnt (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  im2col_pkg::dim_t  fh_i,
  input  im2col_pkg::dim_t  fw_i,
  input  im2col_pkg::size_t ch_col_i,
  input  im2col_pkg::dim_t  batch_i,
  input  logic              offset_adv_i,
  input  logic              batch_inc_i,
  input  logic              batch_clr_i,
  input  logic              done_i,
  output im2col_pkg::dim_t  w_off_o,
  output im2col_pkg::dim_t  h_off_o,
  output im2col_pkg::dim_t  im_c_o,
  output im2col_pkg::dim_t  batch_cnt_o,
  output logic              last_batch_o,
  output logic              last_col_o
);
  import im2col_pkg::*;

  dim_t w_off_q, h_off_q, im_c_q, batch_q;
  size_t col_q;
  logic w_wrap, h_wrap;

  assign w_wrap = (w_off_q == dim_t'(fw_i - 1'b1));
  assign h_wrap = (h_off_q == dim_t'(fh_i - 1'b1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_off_q <= '0;
      h_off_q <= '0;
      im_c_q  <= '0;
      col_q   <= '0;
    end else if (done_i) begin
      w_off_q <= '0;
      h_off_q <= '0;
      im_c_q  <= '0;
      col_q   <= '0;
    end else if (offset_adv_i) begin
      w_off_q <= w_wrap ? '0 : w_off_q + 1'b1;
      if (w_wrap) begin
        h_off_q <= h_wrap ? '0 : h_off_q + 1'b1;
        if (h_wrap) begin
          im_c_q <= im_c_q + 1'b1;  // Whole filter window done.
        end
      end
      col_q <= last_col_o ? '0 : col_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      batch_q <= '0;
    end else if (batch_clr_i) begin
      batch_q <= '0;
    end else if (batch_inc_i) begin
      batch_q <= batch_q + 1'b1;
    end
  end

  assign w_off_o      = w_off_q;
  assign h_off_o      = h_off_q;
  assign im_c_o       = im_c_q;
  assign batch_cnt_o  = batch_q;
  assign last_batch_o = (batch_q == dim_t'(batch_i - 1'b1));
  assign last_col_o   = (col_q == size_t'(ch_col_i - 1'b1));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    offset_adv_i |=> w_off_q < fw_i);

endmodule

// File: im2col_param.f
+incdir+hdl
hdl/im2col_pkg.sv
hdl/im2col_ctrl.sv
hdl/im2col_window_cnt.sv
hdl/im2col_pad_calc.sv
hdl/im2col_addr_pipe.sv
hdl/im2col_param_top.sv
verif/im2col_tb_clk.sv
verif/im2col_tb.sv

// File: verif/im2col_tb.sv
/*
 * im2col parameter engine testbench.
 * Random configurations, descriptor model, FIFO stalls and done handshake.
 */

`timescale 1ns/1ps

module im2col_tb;
  import im2col_pkg::*;

  localparam int WAIT_LIMIT = 5000;  // Cycles per wait loop.

  logic clk_i, rst_ni;
  logic start_i, fifo_full_i, done_ack_i;
  logic fifo_push_o, param_done_o;
  dma_desc_t desc_o;
  ptr_t cfg_src, cfg_dst;
  dim_t cfg_ih, cfg_iw, cfg_fh, cfg_fw, cfg_num_ch, cfg_batch;
  dim_t cfg_pt, cfg_pb, cfg_pl, cfg_pr;
  size_t cfg_ch_col, cfg_nph, cfg_npw;

  logic [31:0] lfsr_q = 32'h3ab4;
  dma_desc_t exp_q[$];
  int value_errs = 0;
  int other_errs = 0;
  int push_cnt = 0;
  int exp_cnt;
  bit zero_pad_run = 0;
  bit timed_out = 0;
  logic full_prev = 1'b0;

  im2col_tb_clk clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

  im2col_param_top dut_i (
    .clk_i, .rst_ni,
    .src_ptr_i (cfg_src), .dst_ptr_i (cfg_dst),
    .ih_i (cfg_ih), .iw_i (cfg_iw), .fh_i (cfg_fh), .fw_i (cfg_fw),
    .num_ch_i (cfg_num_ch), .ch_col_i (cfg_ch_col), .batch_i (cfg_batch),
    .n_patches_h_i (cfg_nph), .n_patches_w_i (cfg_npw),
    .pad_top_i (cfg_pt), .pad_bottom_i (cfg_pb),
    .pad_left_i (cfg_pl), .pad_right_i (cfg_pr),
    .start_i, .fifo_full_i, .done_ack_i,
    .fifo_push_o, .param_done_o, .desc_o
  );

  // Galois LFSR, taps 32, 30, 26, 25.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic void compare_field(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endfunction

  // Column k walks taps first, then channels; batches are innermost.
  function automatic void build_model();
    int w_off, h_off, im_c, zt, zb, zl, zr, idx, n;
    dma_desc_t d;
    n = 0;
    exp_q.delete();
    for (int k = 0; k < int'(cfg_ch_col); k++) begin
      for (int b = 0; b < int'(cfg_batch); b++) begin
        w_off = k % cfg_fw;
        h_off = (k / cfg_fw) % cfg_fh;
        im_c  = k / (cfg_fw * cfg_fh);
        zt = (cfg_pt > h_off) ? cfg_pt - h_off : 0;
        zl = (cfg_pl > w_off) ? cfg_pl - w_off : 0;
        zb = (cfg_pb > cfg_fh - 1 - h_off) ? cfg_pb - (cfg_fh - 1 - h_off) : 0;
        zr = (cfg_pr > cfg_fw - 1 - w_off) ? cfg_pr - (cfg_fw - 1 - w_off) : 0;
        idx = ((b * cfg_num_ch + im_c) * cfg_ih + h_off - cfg_pt + zt) * cfg_iw
              + w_off - cfg_pl + zl;
        d.input_ptr      = cfg_src + idx * 4;
        d.output_ptr     = cfg_dst + n * 4 * cfg_nph * cfg_npw;
        d.n_zeros_top    = zt;
        d.n_zeros_bottom = zb;
        d.n_zeros_left   = zl;
        d.n_zeros_right  = zr;
        d.size_d1        = cfg_npw - zl - zr;
        d.size_d2        = cfg_nph - zt - zb;
        d.in_inc_d2      = cfg_iw - (cfg_npw - zl - zr) + 1;
        exp_q.push_back(d);
        n++;
      end
    end
    exp_cnt = n;
  endfunction

  // Outputs sampled mid-cycle, away from the driving edge.
  always @(negedge clk_i) begin
    dma_desc_t e;
    if (rst_ni && fifo_push_o) begin
      push_cnt++;
      if (full_prev) begin
        other_errs++;
        $display("Push issued after a cycle with the FIFO full");
      end
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Push with no descriptor left in the model");
      end else begin
        e = exp_q.pop_front();
        compare_field("input_ptr", desc_o.input_ptr, e.input_ptr);
        compare_field("output_ptr", desc_o.output_ptr, e.output_ptr);
        compare_field("in_inc_d2", desc_o.in_inc_d2, e.in_inc_d2);
        compare_field("n_zeros_top", desc_o.n_zeros_top, e.n_zeros_top);
        compare_field("n_zeros_bottom", desc_o.n_zeros_bottom, e.n_zeros_bottom);
        compare_field("n_zeros_left", desc_o.n_zeros_left, e.n_zeros_left);
        compare_field("n_zeros_right", desc_o.n_zeros_right, e.n_zeros_right);
        compare_field("size_d1", desc_o.size_d1, e.size_d1);
        compare_field("size_d2", desc_o.size_d2, e.size_d2);
      end
      if (zero_pad_run) begin  // No padding means full rows and columns.
        compare_field("n_zeros_top", desc_o.n_zeros_top, 32'h0);
        compare_field("n_zeros_bottom", desc_o.n_zeros_bottom, 32'h0);
        compare_field("n_zeros_left", desc_o.n_zeros_left, 32'h0);
        compare_field("n_zeros_right", desc_o.n_zeros_right, 32'h0);
        compare_field("size_d1", desc_o.size_d1, cfg_npw);
        compare_field("size_d2", desc_o.size_d2, cfg_nph);
        compare_field("in_inc_d2", desc_o.in_inc_d2, cfg_iw - cfg_npw + 1);
      end
    end
    full_prev = fifo_full_i;
  end

  task automatic draw_config(input bit zero_pad);
    dim_t fh, fw, ih, iw, pt, pb, pl, pr, nc, nb;
    fh = 1 + take_bits(2) % 3;
    fw = 1 + take_bits(2) % 3;
    ih = fh + take_bits(2);
    iw = fw + take_bits(2);
    pt = zero_pad ? 0 : take_bits(2) % fh;  // Pads stay below the filter size.
    pb = zero_pad ? 0 : take_bits(2) % fh;
    pl = zero_pad ? 0 : take_bits(2) % fw;
    pr = zero_pad ? 0 : take_bits(2) % fw;
    nc = 1 + take_bits(1);
    nb = 1 + take_bits(1);
    @(posedge clk_i);
    cfg_fh     <= fh;
    cfg_fw     <= fw;
    cfg_ih     <= ih;
    cfg_iw     <= iw;
    cfg_pt     <= pt;
    cfg_pb     <= pb;
    cfg_pl     <= pl;
    cfg_pr     <= pr;
    cfg_num_ch <= nc;
    cfg_batch  <= nb;
    cfg_ch_col <= fh * fw * nc;
    cfg_nph    <= ih + pt + pb - fh + 1;  // Stride one.
    cfg_npw    <= iw + pl + pr - fw + 1;
    cfg_src    <= take_bits(16) << 2;
    cfg_dst    <= 32'h1000_0000 | (take_bits(16) << 2);
    @(posedge clk_i);
  endtask

  task automatic run_config(input bit zero_pad, input bit full_mode);
    int cycles;
    draw_config(zero_pad);
    zero_pad_run = zero_pad;
    build_model();
    push_cnt = 0;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    cycles = 0;
    while (!param_done_o && !timed_out) begin
      @(posedge clk_i);
      fifo_full_i <= full_mode ? (take_bits(2) == 0) : 1'b0;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        timed_out = 1;
        other_errs++;
        $display("Timeout waiting for the done level");
      end
    end
    fifo_full_i <= 1'b0;
    if (!timed_out) begin
      repeat (4) @(posedge clk_i);
      if (push_cnt != exp_cnt) begin
        other_errs++;
        $display("Wrong descriptor count, %0d pushed, %0d expected", push_cnt, exp_cnt);
      end
      compare_field("param_done_o", param_done_o, 32'h1);
      done_ack_i <= 1'b1;
      @(posedge clk_i);
      done_ack_i <= 1'b0;
      cycles = 0;
      while (param_done_o && !timed_out) begin
        @(posedge clk_i);
        cycles++;
        if (cycles > 20) begin
          timed_out = 1;
          other_errs++;
          $display("Timeout waiting for done to clear after the acknowledge");
        end
      end
    end
  endtask

  initial begin
    int cycles;
    start_i     <= 1'b0;
    fifo_full_i <= 1'b0;
    done_ack_i  <= 1'b0;
    {cfg_src, cfg_dst, cfg_ih, cfg_iw, cfg_fh, cfg_fw} <= '0;
    {cfg_num_ch, cfg_batch, cfg_ch_col, cfg_nph, cfg_npw} <= '0;
    {cfg_pt, cfg_pb, cfg_pl, cfg_pr} <= '0;
    cycles = 0;
    while (!rst_ni && !timed_out) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 50) begin
        timed_out = 1;
        other_errs++;
        $display("Timeout waiting for reset release");
      end
    end
    @(negedge clk_i);
    compare_field("fifo_push_o", fifo_push_o, 32'h0);
    compare_field("param_done_o", param_done_o, 32'h0);
    for (int i = 0; i < 8; i++) begin
      if (!timed_out) begin
        run_config(i == 2 || i == 5, i[0]);  // Odd runs stall on FIFO full.
      end
    end
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/im2col_tb_clk.sv
/*
 * Testbench clock and reset.
 * 40 ns clock, active-low reset held for 10 cycles.
 */

`timescale 1ns/1ps

module im2col_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
